// File: Makefile
all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_exu

run: build
	./obj_dir/Vtb_exu | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_exu

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: logic/exu_alu.sv
`timescale 1ns/1ns

module exu_alu (
  exu_op_if.unit          op,
  output exu_pkg::word_t  result
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = op.op2[4:0];

  always_comb begin
    case (op.alu_op)
      alu_add: begin
        result = op.op1 + op.op2;
      end
      alu_sub: begin
        result = op.op1 - op.op2;
      end
      alu_sll: begin
        result = op.op1 << shamt;
      end
      alu_slt: begin
        result = {31'd0, $signed(op.op1) < $signed(op.op2)};
      end
      alu_sltu: begin
        result = {31'd0, op.op1 < op.op2};
      end
      alu_xor: begin
        result = op.op1 ^ op.op2;
      end
      alu_srl: begin
        result = op.op1 >> shamt;
      end
      alu_sra: begin
        result = $signed(op.op1) >>> shamt;
      end
      alu_or: begin
        result = op.op1 | op.op2;
      end
      alu_and: begin
        result = op.op1 & op.op2;
      end
      // Multiplier ops are handled elsewhere
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: logic/exu_csr.sv
`timescale 1ns/1ns

module exu_csr (
  input  logic            clock,
  input  logic            rst_n,
  exu_op_if.unit          op,
  input  logic            commit,
  input  exu_pkg::word_t  new_value,
  output exu_pkg::word_t  csr_rdata,
  output exu_pkg::word_t  mepc,
  output exu_pkg::word_t  mtvec
);
  import exu_pkg::*;

  csr_addr_t addr;
  word_t     mscratch;

  assign addr = op.imm[11:0];

  always_comb begin
    case (addr)
      csr_mepc:     csr_rdata = mepc;
      csr_mtvec:    csr_rdata = mtvec;
      csr_mscratch: csr_rdata = mscratch;
      default:      csr_rdata = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mepc     <= '0;
      mtvec    <= '0;
      mscratch <= '0;
    end else if (commit) begin
      if (op.is_csr) begin
        case (addr)
          csr_mepc:     mepc     <= new_value;
          // Trap vector stays word aligned
          csr_mtvec:    mtvec    <= {new_value[31:2], 2'b00};
          csr_mscratch: mscratch <= new_value;
          default:      ;
        endcase
      end
      if (op.is_ecall) begin
        mepc <= op.pc;
      end
    end
  end

endmodule

// File: logic/exu_dispatch.sv
`timescale 1ns/1ns

module exu_dispatch (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               in_valid,
  input  exu_pkg::word_t     in_pc,
  input  exu_pkg::word_t     in_op1,
  input  exu_pkg::word_t     in_op2,
  input  exu_pkg::word_t     in_imm,
  input  exu_pkg::alu_op_t   in_alu_op,
  input  exu_pkg::reg_idx_t  in_rd,
  input  exu_pkg::funct3_t   in_func3,
  input  logic               in_is_load,
  input  logic               in_is_store,
  input  logic               in_is_jump,
  input  logic               in_is_branch,
  input  logic               in_is_csr,
  input  logic               in_is_ecall,
  input  logic               in_is_mret,
  input  logic               out_ready,
  input  logic               mem_rvalid,
  input  exu_pkg::word_t     mem_rdata,
  input  logic               mem_wready,
  input  logic               mul_done,
  output logic               in_ready,
  output logic               out_valid,
  output logic               mem_req,
  output logic               mem_we,
  output exu_pkg::word_t     mem_addr,
  output exu_pkg::word_t     mem_wdata,
  output exu_pkg::word_t     load_data,
  exu_op_if.stage            op
);
  import exu_pkg::*;

  logic busy;
  logic accept;
  logic retire;
  logic in_is_mem;
  logic in_is_mul;
  logic op_is_mul;
  logic mem_done;

  assign in_is_mem = in_is_load || in_is_store;
  assign in_is_mul = (in_alu_op == alu_mul) || (in_alu_op == alu_mulhu);
  assign op_is_mul = (op.alu_op == alu_mul) || (op.alu_op == alu_mulhu);

  assign retire   = out_valid && out_ready;
  // Stage can refill in the same cycle its result leaves
  assign in_ready = !busy || retire;
  assign accept   = in_valid && in_ready;
  assign mem_done = (op.is_store && mem_wready) || (op.is_load && mem_rvalid);

  assign op.flush  = flush;
  assign mem_we    = op.is_store;
  assign mem_addr  = op.op1 + op.imm;
  assign mem_wdata = op.op2;

  always_ff @(posedge clock) begin
    if (accept) begin
      op.pc        <= in_pc;
      op.op1       <= in_op1;
      op.op2       <= in_op2;
      op.imm       <= in_imm;
      op.alu_op    <= in_alu_op;
      op.rd        <= in_rd;
      op.func3     <= in_func3;
      op.is_load   <= in_is_load;
      op.is_store  <= in_is_store;
      op.is_jump   <= in_is_jump;
      op.is_branch <= in_is_branch;
      op.is_csr    <= in_is_csr;
      op.is_ecall  <= in_is_ecall;
      op.is_mret   <= in_is_mret;
    end
    if (mem_req && op.is_load && mem_rvalid) begin
      load_data <= mem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      busy      <= 1'b0;
      out_valid <= 1'b0;
      mem_req   <= 1'b0;
      op.start  <= 1'b0;
    end else begin
      op.start <= accept;
      if (accept) begin
        busy      <= 1'b1;
        // ALU, CSR and control flow finish right away
        out_valid <= !(in_is_mem || in_is_mul);
        mem_req   <= in_is_mem;
      end else if (retire) begin
        busy      <= 1'b0;
        out_valid <= 1'b0;
      end else if (busy && !out_valid) begin
        if (mem_req) begin
          if (mem_done) begin
            mem_req   <= 1'b0;
            out_valid <= 1'b1;
          end
        end else if (op_is_mul && mul_done) begin
          out_valid <= 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/exu_mul.sv
`timescale 1ns/1ns

module exu_mul #(
  parameter int XLEN = exu_pkg::xlen
) (
  input  logic            clock,
  input  logic            rst_n,
  exu_op_if.unit          op,
  output exu_pkg::word_t  mul_result,
  output logic            mul_done
);
  import exu_pkg::*;

  localparam int cnt_w = $clog2(XLEN);

  mul_state_t        state;
  logic [cnt_w-1:0]  cnt;
  logic [XLEN-1:0]   mcand;
  logic [2*XLEN-1:0] prod;
  logic [2*XLEN-1:0] base;
  logic [XLEN-1:0]   addend;
  logic [XLEN:0]     sum;
  logic              is_mul_op;
  logic              last;

  assign is_mul_op = (op.alu_op == alu_mul) || (op.alu_op == alu_mulhu);
  assign last      = (cnt == cnt_w'(XLEN - 1));

  // Product register holds the accumulator on top and the multiplier below
  always_comb begin
    if (state == ms_busy) begin
      base   = prod;
      addend = mcand;
    end else begin
      base   = {{XLEN{1'b0}}, op.op2};
      addend = op.op1;
    end
    sum = {1'b0, base[2*XLEN-1:XLEN]} + {1'b0, (base[0] ? addend : '0)};
  end

  always_ff @(posedge clock) begin
    if (!rst_n || op.flush) begin
      state <= ms_idle;
      cnt   <= '0;
    end else begin
      case (state)
        ms_busy: begin
          prod <= {sum, base[XLEN-1:1]};
          cnt  <= cnt + 1'b1;
          if (last) begin
            state <= ms_done;
          end
        end
        default: begin
          // First step is taken together with the start pulse
          if (op.start && is_mul_op) begin
            mcand <= op.op1;
            prod  <= {sum, base[XLEN-1:1]};
            cnt   <= cnt_w'(1);
            state <= ms_busy;
          end
        end
      endcase
    end
  end

  // Final step is in flight while this is high
  assign mul_done   = (state == ms_busy) && last;
  assign mul_result = (op.alu_op == alu_mulhu) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

endmodule

// File: logic/exu_op_if.sv
`timescale 1ns/1ns

interface exu_op_if #(
  parameter int XLEN = exu_pkg::xlen
);
  import exu_pkg::*;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] imm;
  alu_op_t         alu_op;
  reg_idx_t        rd;
  funct3_t         func3;
  logic            is_load;
  logic            is_store;
  logic            is_jump;
  logic            is_branch;
  logic            is_csr;
  logic            is_ecall;
  logic            is_mret;
  logic            start;
  logic            flush;

  modport stage (
    output pc, op1, op2, imm, alu_op, rd, func3,
    output is_load, is_store, is_jump, is_branch, is_csr, is_ecall, is_mret,
    output start, flush
  );

  modport unit (
    input pc, op1, op2, imm, alu_op, rd, func3,
    input is_load, is_store, is_jump, is_branch, is_csr, is_ecall, is_mret,
    input start, flush
  );

endinterface

// File: logic/exu_pkg.sv
package exu_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [2:0]      funct3_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_mul,
    alu_mulhu
  } alu_op_t;

  // CSR instruction forms
  localparam funct3_t f3_csrrw  = 3'b001;
  localparam funct3_t f3_csrrs  = 3'b010;
  localparam funct3_t f3_csrrc  = 3'b011;
  localparam funct3_t f3_csrrwi = 3'b101;
  localparam funct3_t f3_csrrsi = 3'b110;
  localparam funct3_t f3_csrrci = 3'b111;

  // Branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  localparam csr_addr_t csr_mepc     = 12'h341;
  localparam csr_addr_t csr_mtvec    = 12'h305;
  localparam csr_addr_t csr_mscratch = 12'h340;

  typedef enum logic [1:0] {
    ms_idle,
    ms_busy,
    ms_done
  } mul_state_t;

endpackage

// File: logic/exu_retire.sv
`timescale 1ns/1ns

module exu_retire (
  exu_op_if.unit          op,
  input  exu_pkg::word_t  alu_result,
  input  exu_pkg::word_t  mul_result,
  input  exu_pkg::word_t  csr_rdata,
  input  exu_pkg::word_t  mepc,
  input  exu_pkg::word_t  mtvec,
  input  exu_pkg::word_t  load_data,
  output exu_pkg::word_t  wb_data,
  output exu_pkg::word_t  csr_new_value,
  output exu_pkg::word_t  next_pc,
  output logic            redirect
);
  import exu_pkg::*;

  logic is_mul;
  logic alu_zero;
  logic taken;

  assign is_mul   = (op.alu_op == alu_mul) || (op.alu_op == alu_mulhu);
  assign alu_zero = (alu_result == '0);

  always_comb begin
    if (op.rd == '0) wb_data = '0;
    else if (op.is_load) wb_data = load_data;
    else if (op.is_jump) wb_data = op.pc + 32'd4;
    else if (op.is_csr) wb_data = csr_rdata;
    else if (is_mul) wb_data = mul_result;
    else wb_data = alu_result;
  end

  always_comb begin
    case (op.func3)
      f3_csrrw, f3_csrrwi: csr_new_value = op.op1;
      f3_csrrs, f3_csrrsi: csr_new_value = csr_rdata | op.op1;
      f3_csrrc, f3_csrrci: csr_new_value = csr_rdata & ~op.op1;
      default:             csr_new_value = csr_rdata;
    endcase
  end

  // Decode picks sub, xor, slt or sltu so each condition is a zero test
  always_comb begin
    case (op.func3)
      f3_beq:          taken = alu_zero;
      f3_bne:          taken = !alu_zero;
      f3_blt, f3_bltu: taken = !alu_zero;
      f3_bge, f3_bgeu: taken = alu_zero;
      default:         taken = 1'b0;
    endcase
    taken = taken && op.is_branch;
  end

  assign redirect = taken || op.is_jump || op.is_ecall || op.is_mret;

  always_comb begin
    if (op.is_ecall) next_pc = mtvec;
    else if (op.is_mret) next_pc = mepc;
    else if (op.is_jump) next_pc = op.op1 + op.imm;
    else if (taken) next_pc = op.pc + op.imm;
    else next_pc = op.pc + 32'd4;
  end

endmodule

// File: logic/exu_top.sv
`timescale 1ns/1ns

module exu_top #(
  parameter int XLEN = exu_pkg::xlen
) (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               in_valid,
  input  exu_pkg::word_t     in_pc,
  input  exu_pkg::word_t     in_op1,
  input  exu_pkg::word_t     in_op2,
  input  exu_pkg::word_t     in_imm,
  input  exu_pkg::alu_op_t   in_alu_op,
  input  exu_pkg::reg_idx_t  in_rd,
  input  exu_pkg::funct3_t   in_func3,
  input  logic               in_is_load,
  input  logic               in_is_store,
  input  logic               in_is_jump,
  input  logic               in_is_branch,
  input  logic               in_is_csr,
  input  logic               in_is_ecall,
  input  logic               in_is_mret,
  output logic               in_ready,
  output logic               out_valid,
  output exu_pkg::reg_idx_t  out_rd,
  output exu_pkg::word_t     out_wb_data,
  output exu_pkg::word_t     out_pc,
  output exu_pkg::word_t     out_next_pc,
  output logic               out_redirect,
  input  logic               out_ready,
  output logic               mem_req,
  output logic               mem_we,
  output exu_pkg::word_t     mem_addr,
  output exu_pkg::word_t     mem_wdata,
  input  logic               mem_rvalid,
  input  exu_pkg::word_t     mem_rdata,
  input  logic               mem_wready
);
  import exu_pkg::*;

  word_t alu_result;
  word_t mul_result;
  word_t csr_rdata;
  word_t csr_new_value;
  word_t mepc;
  word_t mtvec;
  word_t load_data;
  logic  mul_done;
  logic  commit;

  exu_op_if #(.XLEN(XLEN)) op_bus ();

  assign commit = out_valid && out_ready;
  assign out_rd = op_bus.rd;
  assign out_pc = op_bus.pc;

  exu_dispatch u_dispatch (
    .clock        (clock),
    .rst_n        (rst_n),
    .flush        (flush),
    .in_valid     (in_valid),
    .in_pc        (in_pc),
    .in_op1       (in_op1),
    .in_op2       (in_op2),
    .in_imm       (in_imm),
    .in_alu_op    (in_alu_op),
    .in_rd        (in_rd),
    .in_func3     (in_func3),
    .in_is_load   (in_is_load),
    .in_is_store  (in_is_store),
    .in_is_jump   (in_is_jump),
    .in_is_branch (in_is_branch),
    .in_is_csr    (in_is_csr),
    .in_is_ecall  (in_is_ecall),
    .in_is_mret   (in_is_mret),
    .out_ready    (out_ready),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .mem_wready   (mem_wready),
    .mul_done     (mul_done),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .load_data    (load_data),
    .op           (op_bus.stage)
  );

  exu_alu u_alu (
    .op     (op_bus.unit),
    .result (alu_result)
  );

  exu_mul #(.XLEN(XLEN)) u_mul (
    .clock      (clock),
    .rst_n      (rst_n),
    .op         (op_bus.unit),
    .mul_result (mul_result),
    .mul_done   (mul_done)
  );

  exu_csr u_csr (
    .clock     (clock),
    .rst_n     (rst_n),
    .op        (op_bus.unit),
    .commit    (commit),
    .new_value (csr_new_value),
    .csr_rdata (csr_rdata),
    .mepc      (mepc),
    .mtvec     (mtvec)
  );

  exu_retire u_retire (
    .op            (op_bus.unit),
    .alu_result    (alu_result),
    .mul_result    (mul_result),
    .csr_rdata     (csr_rdata),
    .mepc          (mepc),
    .mtvec         (mtvec),
    .load_data     (load_data),
    .wb_data       (out_wb_data),
    .csr_new_value (csr_new_value),
    .next_pc       (out_next_pc),
    .redirect      (out_redirect)
  );

endmodule

// File: sim/exu_sva.sv
`timescale 1ns/1ns

module exu_sva (
  input logic               clock,
  input logic               rst_n,
  input logic               flush,
  input logic               in_ready,
  input logic               out_valid,
  input logic               out_ready,
  input exu_pkg::reg_idx_t  out_rd,
  input exu_pkg::word_t     out_wb_data,
  input exu_pkg::word_t     out_next_pc,
  input logic               out_redirect,
  input logic               mem_req,
  input logic               mem_we,
  input exu_pkg::word_t     mem_addr,
  input exu_pkg::word_t     mem_wdata,
  input logic               mem_rvalid,
  input logic               mem_wready
);

  logic mem_done;

  assign mem_done = mem_we ? mem_wready : mem_rvalid;

  // Result holds until the next stage takes it
  out_hold: assert property (@(posedge clock) disable iff (!rst_n)
    out_valid && !out_ready && !flush |=> out_valid && $stable(out_wb_data)
      && $stable(out_next_pc) && $stable(out_redirect) && $stable(out_rd))
    else $error("out_valid or its data changed while stalled");

  mem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    mem_req && !mem_done && !flush |=> mem_req && $stable(mem_addr) && $stable(mem_wdata))
    else $error("memory request changed before completion");

  stall_blocks_input: assert property (@(posedge clock) disable iff (!rst_n)
    out_valid && !out_ready |-> !in_ready)
    else $error("in_ready high while the result waits");

endmodule

bind exu_top exu_sva u_sva (.*);

// File: sim/tb_exu.sv
`timescale 1ns/1ns

module tb_exu;
  import exu_pkg::*;

  logic     clock;
  logic     rst_n;
  logic     flush;
  logic     in_valid;
  word_t    in_pc;
  word_t    in_op1;
  word_t    in_op2;
  word_t    in_imm;
  alu_op_t  in_alu_op;
  reg_idx_t in_rd;
  funct3_t  in_func3;
  logic     in_is_load;
  logic     in_is_store;
  logic     in_is_jump;
  logic     in_is_branch;
  logic     in_is_csr;
  logic     in_is_ecall;
  logic     in_is_mret;
  logic     in_ready;
  logic     out_valid;
  reg_idx_t out_rd;
  word_t    out_wb_data;
  word_t    out_pc;
  word_t    out_next_pc;
  logic     out_redirect;
  logic     out_ready;
  logic     mem_req;
  logic     mem_we;
  word_t    mem_addr;
  word_t    mem_wdata;
  logic     mem_rvalid;
  word_t    mem_rdata;
  logic     mem_wready;

  word_t    mem_array [0:63];
  int       mem_delay;

  // Last result seen on the completion side
  word_t    got_wb;
  word_t    got_next_pc;
  word_t    got_pc;
  reg_idx_t got_rd;
  logic     got_redirect;
  int       got_lat;

  // Expected CSR contents
  word_t    mscratch_m;
  word_t    mtvec_m;
  word_t    mepc_m;

  exu_top #(.XLEN(xlen)) DUT (.*);

  always #5 clock = ~clock;

  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t alu_model(input alu_op_t f, input word_t a, input word_t b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (f)
      alu_add:  return a + b;
      alu_sub:  return a + ~b + 32'd1;
      alu_sll:  return a << b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return ext[31:0];
      alu_or:   return a | b;
      alu_and:  return a & b;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ALU op that decode pairs with each branch form
  function automatic alu_op_t branch_alu_op(input funct3_t f3);
    case (f3)
      f3_beq:         return alu_sub;
      f3_bne:         return alu_xor;
      f3_blt, f3_bge: return alu_slt;
      default:        return alu_sltu;
    endcase
  endfunction

  function automatic word_t csr_combine(input funct3_t f3, input word_t old, input word_t v);
    case (f3)
      f3_csrrw, f3_csrrwi: return v;
      f3_csrrs, f3_csrrsi: return old | v;
      default:             return old & ~v;
    endcase
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic clear_fields();
    in_pc        = '0;
    in_op1       = '0;
    in_op2       = '0;
    in_imm       = '0;
    in_alu_op    = alu_add;
    in_rd        = '0;
    in_func3     = '0;
    in_is_load   = 1'b0;
    in_is_store  = 1'b0;
    in_is_jump   = 1'b0;
    in_is_branch = 1'b0;
    in_is_csr    = 1'b0;
    in_is_ecall  = 1'b0;
    in_is_mret   = 1'b0;
  endtask

  task automatic issue_instr();
    int tries;
    tries = 0;
    in_valid = 1'b1;
    @(negedge clock);
    while (!in_ready) begin
      tries++;
      if (tries > 100) begin
        stop_with_failure("in_ready stayed low and the instruction was never accepted");
      end
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    in_valid = 1'b0;
  endtask

  // Latency counts the accept edge as cycle one
  task automatic wait_out_valid();
    got_lat = 0;
    do begin
      @(negedge clock);
      got_lat++;
      if (got_lat > 100) begin
        stop_with_failure("out_valid never rose after an accepted instruction");
      end
    end while (!out_valid);
    got_wb       = out_wb_data;
    got_next_pc  = out_next_pc;
    got_pc       = out_pc;
    got_rd       = out_rd;
    got_redirect = out_redirect;
  endtask

  task automatic execute();
    issue_instr();
    wait_out_valid();
    // Result leaves at this edge while out_ready is high
    @(posedge clock);
    #1;
  endtask

  task automatic alu_ops();
    word_t a;
    word_t b;
    for (int i = 0; i < 10; i++) begin
      for (int k = 0; k < 3; k++) begin
        a = $urandom();
        b = $urandom();
        clear_fields();
        in_pc     = word_t'($urandom_range(1023, 0)) << 2;
        in_op1    = a;
        in_op2    = b;
        in_alu_op = alu_op_t'(i);
        // Last round targets x0
        in_rd     = (k == 2) ? 5'd0 : reg_idx_t'($urandom_range(31, 1));
        execute();
        check_value("latency", 32'(got_lat), 32'd1);
        check_value("out_rd", 32'(got_rd), 32'(in_rd));
        check_value("out_pc", got_pc, in_pc);
        check_value("out_wb_data", got_wb, (k == 2) ? 32'd0 : alu_model(alu_op_t'(i), a, b));
        check_value("out_next_pc", got_next_pc, in_pc + 32'd4);
        check_value("out_redirect", 32'(got_redirect), 32'd0);
      end
    end
  endtask

  task automatic mul_ops();
    word_t a;
    word_t b;
    logic [63:0] prod;
    for (int k = 0; k < 8; k++) begin
      a = $urandom();
      b = $urandom();
      if (k < 2) begin
        a = '1;
        b = '1;
      end
      prod = {32'd0, a} * {32'd0, b};
      clear_fields();
      in_op1    = a;
      in_op2    = b;
      in_alu_op = (k % 2 == 1) ? alu_mulhu : alu_mul;
      in_rd     = 5'd7;
      execute();
      check_value("latency", 32'(got_lat), 32'd33);
      check_value("out_wb_data", got_wb, (k % 2 == 1) ? prod[63:32] : prod[31:0]);
    end
  endtask

  task automatic load_store();
    word_t base [0:3];
    word_t offs [0:3];
    word_t data [0:3];
    word_t addr;
    // Each slot owns its own 64-byte region
    for (int k = 0; k < 4; k++) begin
      base[k] = word_t'(k * 64) + (word_t'($urandom_range(7, 0)) << 2);
      offs[k] = word_t'($urandom_range(7, 0)) << 2;
      data[k] = $urandom();
    end
    for (int pass = 0; pass < 3; pass++) begin
      for (int k = 0; k < 4; k++) begin
        addr = base[k] + offs[k];
        clear_fields();
        in_pc       = word_t'(k) << 2;
        in_op1      = base[k];
        in_op2      = data[k];
        in_imm      = offs[k];
        in_is_load  = (pass != 1);
        in_is_store = (pass == 1);
        in_rd       = (pass == 1) ? 5'd0 : reg_idx_t'(k + 1);
        execute();
        check_value("out_next_pc", got_next_pc, in_pc + 32'd4);
        if (pass == 0) begin
          check_value("out_wb_data", got_wb, fill_word(addr));
        end else if (pass == 1) begin
          check_value("out_wb_data", got_wb, 32'd0);
          check_value("mem_array", mem_array[addr[7:2]], data[k]);
        end else begin
          check_value("out_wb_data", got_wb, data[k]);
        end
      end
    end
  endtask

  task automatic branches_jump();
    funct3_t forms [0:5];
    word_t   a;
    word_t   b;
    word_t   off;
    logic    taken;
    forms = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 3; k++) begin
        a     = $urandom();
        b     = (k == 0) ? a : $urandom();
        off   = word_t'($urandom_range(255, 1)) << 2;
        taken = branch_taken(forms[i], a, b);
        clear_fields();
        in_pc        = word_t'($urandom_range(4095, 512)) << 2;
        in_op1       = a;
        in_op2       = b;
        in_imm       = (k == 2) ? 32'd0 - off : off;
        in_alu_op    = branch_alu_op(forms[i]);
        in_func3     = forms[i];
        in_is_branch = 1'b1;
        execute();
        check_value("latency", 32'(got_lat), 32'd1);
        check_value("out_redirect", 32'(got_redirect), 32'(taken));
        check_value("out_next_pc", got_next_pc, taken ? in_pc + in_imm : in_pc + 32'd4);
        check_value("out_wb_data", got_wb, 32'd0);
      end
    end
    clear_fields();
    in_pc      = word_t'($urandom_range(4095, 0)) << 2;
    in_op1     = word_t'($urandom_range(4095, 0)) << 2;
    in_imm     = word_t'($urandom_range(255, 0)) << 2;
    in_rd      = 5'd1;
    in_is_jump = 1'b1;
    execute();
    check_value("out_redirect", 32'(got_redirect), 32'd1);
    check_value("out_next_pc", got_next_pc, in_op1 + in_imm);
    check_value("out_wb_data", got_wb, in_pc + 32'd4);
  endtask

  task automatic csr_access(input csr_addr_t addr, input funct3_t f3, input word_t v);
    word_t old;
    word_t nv;
    case (addr)
      csr_mscratch: old = mscratch_m;
      csr_mtvec:    old = mtvec_m;
      default:      old = mepc_m;
    endcase
    nv = csr_combine(f3, old, v);
    clear_fields();
    in_op1    = v;
    in_imm    = word_t'(addr);
    in_func3  = f3;
    in_is_csr = 1'b1;
    in_rd     = 5'd5;
    execute();
    check_value("latency", 32'(got_lat), 32'd1);
    check_value("out_wb_data", got_wb, old);
    case (addr)
      csr_mscratch: mscratch_m = nv;
      csr_mtvec:    mtvec_m = {nv[31:2], 2'b00};
      default:      mepc_m = nv;
    endcase
  endtask

  task automatic csr_traps();
    funct3_t forms [0:5];
    forms = '{f3_csrrw, f3_csrrs, f3_csrrc, f3_csrrwi, f3_csrrsi, f3_csrrci};
    for (int i = 0; i < 6; i++) begin
      csr_access(csr_mscratch, forms[i], $urandom());
      csr_access(csr_mtvec, forms[i], $urandom());
    end
    // Set with zero reads back what was left behind
    csr_access(csr_mscratch, f3_csrrs, 32'd0);
    csr_access(csr_mtvec, f3_csrrs, 32'd0);
    clear_fields();
    in_pc       = word_t'($urandom_range(4095, 0)) << 2;
    in_is_ecall = 1'b1;
    execute();
    check_value("out_redirect", 32'(got_redirect), 32'd1);
    check_value("out_next_pc", got_next_pc, mtvec_m);
    mepc_m = in_pc;
    csr_access(csr_mepc, f3_csrrs, 32'd0);
    clear_fields();
    in_pc      = word_t'($urandom_range(4095, 0)) << 2;
    in_is_mret = 1'b1;
    execute();
    check_value("out_redirect", 32'(got_redirect), 32'd1);
    check_value("out_next_pc", got_next_pc, mepc_m);
  endtask

  task automatic stall_and_flush();
    logic [63:0] prod;
    out_ready = 1'b0;
    clear_fields();
    in_op1    = $urandom();
    in_op2    = $urandom();
    in_alu_op = alu_xor;
    in_rd     = 5'd9;
    issue_instr();
    wait_out_valid();
    check_value("out_wb_data", got_wb, in_op1 ^ in_op2);
    repeat (6) begin
      @(negedge clock);
      check_value("out_valid", 32'(out_valid), 32'd1);
      check_value("in_ready", 32'(in_ready), 32'd0);
      check_value("out_wb_data", out_wb_data, got_wb);
      check_value("out_next_pc", out_next_pc, got_next_pc);
    end
    @(posedge clock);
    #1;
    out_ready = 1'b1;
    @(negedge clock);
    check_value("in_ready", 32'(in_ready), 32'd1);
    @(posedge clock);
    #1;
    clear_fields();
    in_op1    = $urandom();
    in_op2    = $urandom();
    in_alu_op = alu_mul;
    in_rd     = 5'd3;
    issue_instr();
    repeat (10) @(posedge clock);
    #1;
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
    // The flushed multiply must never complete
    repeat (40) begin
      @(negedge clock);
      check_value("out_valid", 32'(out_valid), 32'd0);
    end
    check_value("in_ready", 32'(in_ready), 32'd1);
    @(posedge clock);
    #1;
    in_op1 = $urandom();
    in_op2 = $urandom();
    prod   = {32'd0, in_op1} * {32'd0, in_op2};
    execute();
    check_value("latency", 32'(got_lat), 32'd33);
    check_value("out_wb_data", got_wb, prod[31:0]);
  endtask

  // Memory responder answers after a random 0 to 5 cycle delay
  initial begin
    mem_rvalid = 1'b0;
    mem_wready = 1'b0;
    mem_rdata  = '0;
    mem_delay  = -1;
    for (int i = 0; i < 64; i++) begin
      mem_array[i] = fill_word(word_t'(i) << 2);
    end
    forever begin
      @(posedge clock);
      #1;
      mem_rvalid = 1'b0;
      mem_wready = 1'b0;
      if (!mem_req) begin
        mem_delay = -1;
      end else if (mem_delay < 0) begin
        mem_delay = $urandom_range(5, 0);
      end
      if (mem_req && mem_delay == 0) begin
        if (mem_we) begin
          mem_array[mem_addr[7:2]] = mem_wdata;
          mem_wready = 1'b1;
        end else begin
          mem_rdata  = mem_array[mem_addr[7:2]];
          mem_rvalid = 1'b1;
        end
      end else if (mem_req) begin
        mem_delay--;
      end
    end
  end

  initial begin
    void'($urandom(32'h5a8f_0807));
    clock      = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    mscratch_m = '0;
    mtvec_m    = '0;
    mepc_m     = '0;
    clear_fields();
    repeat (16) @(posedge clock);
    #1;
    rst_n = 1'b1;
    alu_ops();
    mul_ops();
    load_store();
    branches_jump();
    csr_traps();
    stall_and_flush();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: tb.f
logic/exu_pkg.sv
logic/exu_op_if.sv
logic/exu_dispatch.sv
logic/exu_alu.sv
logic/exu_mul.sv
logic/exu_csr.sv
logic/exu_retire.sv
logic/exu_top.sv
sim/exu_sva.sv
sim/tb_exu.sv
